//--- verilog/bridge_pkg.sv
// Widths and encodings shared by the AXI4-to-APB bridge
// Single-beat 32-bit accesses, eight APB slaves with a 4 KB window each
// Only OKAY and SLVERR are ever returned on the AXI side
package bridge_pkg;

  localparam int ADDR_W     = 32;   // AXI address
  localparam int DATA_W     = 32;   // AXI and APB data
  localparam int ID_W       = 8;
  localparam int APB_ADDR_W = 12;   // Per-slave window, 4 KB
  localparam int NUM_SLAVES = 8;
  localparam int SEL_W      = $clog2(NUM_SLAVES);

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } apb_op_e;

  // APB transfer phases
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_BRESP,
    RS_RRESP
  } resp_state_e;

endpackage

//--- verilog/apb_cmd_if.sv
// Decoded APB command from the AXI request stage to the APB master
// Transfers when valid and ready are both high; fields hold while valid
`timescale 1ns/1ps

interface apb_cmd_if;
  import bridge_pkg::*;

  logic                  valid;
  logic                  ready;
  apb_op_e               op;
  logic [SEL_W-1:0]      sel;     // Target slave index
  logic [APB_ADDR_W-1:0] paddr;
  logic [DATA_W-1:0]     wdata;
  logic [ID_W-1:0]       id;      // Echoed in the AXI response

  modport decode (output valid, op, sel, paddr, wdata, id, input ready);

  modport execute (input valid, op, sel, paddr, wdata, id, output ready);

endinterface

//--- verilog/apb_done_if.sv
// Outcome of a finished APB transfer, from the APB master to the response stage
// Same valid/ready rule as the command interface
`timescale 1ns/1ps

interface apb_done_if;
  import bridge_pkg::*;

  logic              valid;
  logic              ready;
  apb_op_e           op;
  logic [DATA_W-1:0] rdata;   // Meaningful for reads only
  logic              err;     // PSLVERR of the addressed slave
  logic [ID_W-1:0]   id;

  modport execute (output valid, op, rdata, err, id, input ready);

  modport result (input valid, op, rdata, err, id, output ready);

endinterface

//--- verilog/axi_req_decode.sv
// AXI request intake, one transaction at a time
// A read beats a write offered in the same cycle; AW and W must arrive together
// Address bits above 14 are ignored, so no decode error exists
`timescale 1ns/1ps

module axi_req_decode (
  input  logic                          ACLK,
  input  logic                          ARESETn,
  input  logic [bridge_pkg::ADDR_W-1:0] AWADDR_i,
  input  logic [bridge_pkg::ID_W-1:0]   AWID_i,
  input  logic                          AWVALID_i,
  output logic                          AWREADY_o,
  input  logic [bridge_pkg::DATA_W-1:0] WDATA_i,
  input  logic                          WVALID_i,
  output logic                          WREADY_o,
  input  logic [bridge_pkg::ADDR_W-1:0] ARADDR_i,
  input  logic [bridge_pkg::ID_W-1:0]   ARID_i,
  input  logic                          ARVALID_i,
  output logic                          ARREADY_o,
  input  logic                          free_i,     // Response handshake done
  apb_cmd_if.decode                     cmd
);
  import bridge_pkg::*;

  logic              busy;      // Set from accept until the response is taken
  logic              take_rd;
  logic              take_wr;
  logic [ADDR_W-1:0] req_addr;

  // -------------------------------------------------------------------------
  // Arbitration and AXI ready
  // -------------------------------------------------------------------------
  assign take_rd  = ~busy & ARVALID_i;
  assign take_wr  = ~busy & AWVALID_i & WVALID_i & ~ARVALID_i;

  assign ARREADY_o = take_rd;
  assign AWREADY_o = take_wr;
  assign WREADY_o  = take_wr;   // Address and data accepted in the same cycle

  assign req_addr = take_rd ? ARADDR_i : AWADDR_i;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      busy      <= 1'b0;
      cmd.valid <= 1'b0;
    end
    else
    begin
      if (take_rd | take_wr)
        busy <= 1'b1;
      else if (free_i)
        busy <= 1'b0;

      if (take_rd | take_wr)
        cmd.valid <= 1'b1;
      else if (cmd.ready)
        cmd.valid <= 1'b0;    // Taken by the APB master
    end
  end

  // Command fields, loaded on accept
  always_ff @(posedge ACLK)
  begin
    if (take_rd | take_wr)
    begin
      cmd.op    <= take_rd ? OP_READ : OP_WRITE;
      cmd.sel   <= req_addr[APB_ADDR_W+SEL_W-1:APB_ADDR_W];   // Bits 14:12
      cmd.paddr <= req_addr[APB_ADDR_W-1:0];
      cmd.wdata <= WDATA_i;
      cmd.id    <= take_rd ? ARID_i : AWID_i;
    end
  end

endmodule

//--- verilog/apb_master_fsm.sv
// APB master: one setup cycle, then access until the selected PREADY
// PSEL is one-hot and low when idle; PENABLE only in the access phase
// Return signals are taken from the addressed slave alone
`timescale 1ns/1ps

module apb_master_fsm (
  input  logic                                   ACLK,
  input  logic                                   ARESETn,
  apb_cmd_if.execute                             cmd,
  apb_done_if.execute                            done,
  output logic [bridge_pkg::NUM_SLAVES-1:0]      PSEL_o,
  output logic                                   PENABLE_o,
  output logic                                   PWRITE_o,
  output logic [bridge_pkg::APB_ADDR_W-1:0]      PADDR_o,
  output logic [bridge_pkg::DATA_W-1:0]          PWDATA_o,
  input  logic [bridge_pkg::NUM_SLAVES-1:0]
               [bridge_pkg::DATA_W-1:0]          PRDATA_i,
  input  logic [bridge_pkg::NUM_SLAVES-1:0]      PREADY_i,
  input  logic [bridge_pkg::NUM_SLAVES-1:0]      PSLVERR_i
);
  import bridge_pkg::*;

  apb_state_e            state_q;
  apb_op_e               op_q;
  logic [SEL_W-1:0]      sel_q;
  logic [APB_ADDR_W-1:0] paddr_q;
  logic [DATA_W-1:0]     wdata_q;
  logic [ID_W-1:0]       id_q;

  logic                  cmd_take;
  logic                  access_end;
  logic                  pready_sel;
  logic [DATA_W-1:0]     prdata_sel;
  logic                  pslverr_sel;

  // Idle and no outcome left waiting for the response stage
  assign cmd.ready  = (state_q == ST_IDLE) & ~done.valid;
  assign cmd_take   = cmd.valid & cmd.ready;

  assign pready_sel  = PREADY_i[sel_q];
  assign prdata_sel  = PRDATA_i[sel_q];
  assign pslverr_sel = PSLVERR_i[sel_q];
  assign access_end  = (state_q == ST_ACCESS) & pready_sel;

  // -------------------------------------------------------------------------
  // APB outputs
  // -------------------------------------------------------------------------
  always_comb
  begin
    PSEL_o = '0;
    if (state_q != ST_IDLE)
      PSEL_o[sel_q] = 1'b1;
  end

  assign PENABLE_o = (state_q == ST_ACCESS);
  assign PWRITE_o  = (op_q == OP_WRITE);
  assign PADDR_o   = paddr_q;
  assign PWDATA_o  = wdata_q;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q    <= ST_IDLE;
      done.valid <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:   if (cmd_take) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS: if (pready_sel) state_q <= ST_IDLE;   // Wait states otherwise
        default:   state_q <= ST_IDLE;
      endcase

      if (access_end)
        done.valid <= 1'b1;
      else if (done.ready)
        done.valid <= 1'b0;
    end
  end

  // Latched command and transfer outcome
  always_ff @(posedge ACLK)
  begin
    if (cmd_take)
    begin
      op_q    <= cmd.op;
      sel_q   <= cmd.sel;
      paddr_q <= cmd.paddr;
      wdata_q <= cmd.wdata;
      id_q    <= cmd.id;
    end
    if (access_end)
    begin
      done.op    <= op_q;
      done.rdata <= prdata_sel;
      done.err   <= pslverr_sel;
      done.id    <= id_q;
    end
  end

endmodule

//--- verilog/axi_resp_gen.sv
// Turns a finished APB transfer into an AXI B or R response
// Response is held until the master takes it; free_o pulses on that handshake
`timescale 1ns/1ps

module axi_resp_gen (
  input  logic                          ACLK,
  input  logic                          ARESETn,
  apb_done_if.result                    done,
  output logic [bridge_pkg::ID_W-1:0]   BID_o,
  output bridge_pkg::axi_resp_e         BRESP_o,
  output logic                          BVALID_o,
  input  logic                          BREADY_i,
  output logic [bridge_pkg::ID_W-1:0]   RID_o,
  output logic [bridge_pkg::DATA_W-1:0] RDATA_o,
  output bridge_pkg::axi_resp_e         RRESP_o,
  output logic                          RVALID_o,
  input  logic                          RREADY_i,
  output logic                          free_o
);
  import bridge_pkg::*;

  resp_state_e       state_q;
  axi_resp_e         resp_q;
  logic [ID_W-1:0]   id_q;
  logic [DATA_W-1:0] rdata_q;
  logic              done_take;

  assign done.ready = (state_q == RS_IDLE);
  assign done_take  = done.valid & done.ready;

  assign BVALID_o = (state_q == RS_BRESP);
  assign RVALID_o = (state_q == RS_RRESP);
  assign BID_o    = id_q;
  assign RID_o    = id_q;
  assign BRESP_o  = resp_q;
  assign RRESP_o  = resp_q;
  assign RDATA_o  = rdata_q;

  assign free_o = (BVALID_o & BREADY_i) | (RVALID_o & RREADY_i);

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      state_q <= RS_IDLE;
    else
    begin
      case (state_q)
        RS_IDLE:  if (done_take) state_q <= (done.op == OP_WRITE) ? RS_BRESP : RS_RRESP;
        RS_BRESP: if (BREADY_i) state_q <= RS_IDLE;
        RS_RRESP: if (RREADY_i) state_q <= RS_IDLE;
        default:  state_q <= RS_IDLE;
      endcase
    end
  end

  always_ff @(posedge ACLK)
  begin
    if (done_take)
    begin
      resp_q  <= done.err ? SLVERR : OKAY;   // PSLVERR maps to SLVERR
      id_q    <= done.id;
      rdata_q <= done.rdata;
    end
  end

endmodule

//--- verilog/axi_apb_bridge.sv
// AXI4 to APB bridge, 32-bit single-beat accesses, one transfer in flight
// Slave index from address bits 14:12; no bursts, strobes or decode errors
// PRDATA, PREADY and PSLVERR come in per slave, PSEL goes out one-hot
`timescale 1ns/1ps

module axi_apb_bridge (
  input  logic                                   ACLK,
  input  logic                                   ARESETn,
  // AXI write address and data
  input  logic [bridge_pkg::ADDR_W-1:0]          AWADDR_i,
  input  logic [bridge_pkg::ID_W-1:0]            AWID_i,
  input  logic                                   AWVALID_i,
  output logic                                   AWREADY_o,
  input  logic [bridge_pkg::DATA_W-1:0]          WDATA_i,
  input  logic                                   WVALID_i,
  output logic                                   WREADY_o,
  // AXI write response
  output logic [bridge_pkg::ID_W-1:0]            BID_o,
  output bridge_pkg::axi_resp_e                  BRESP_o,
  output logic                                   BVALID_o,
  input  logic                                   BREADY_i,
  // AXI read address and data
  input  logic [bridge_pkg::ADDR_W-1:0]          ARADDR_i,
  input  logic [bridge_pkg::ID_W-1:0]            ARID_i,
  input  logic                                   ARVALID_i,
  output logic                                   ARREADY_o,
  output logic [bridge_pkg::ID_W-1:0]            RID_o,
  output logic [bridge_pkg::DATA_W-1:0]          RDATA_o,
  output bridge_pkg::axi_resp_e                  RRESP_o,
  output logic                                   RVALID_o,
  input  logic                                   RREADY_i,
  // APB master
  output logic [bridge_pkg::NUM_SLAVES-1:0]      PSEL_o,
  output logic                                   PENABLE_o,
  output logic                                   PWRITE_o,
  output logic [bridge_pkg::APB_ADDR_W-1:0]      PADDR_o,
  output logic [bridge_pkg::DATA_W-1:0]          PWDATA_o,
  input  logic [bridge_pkg::NUM_SLAVES-1:0]
               [bridge_pkg::DATA_W-1:0]          PRDATA_i,
  input  logic [bridge_pkg::NUM_SLAVES-1:0]      PREADY_i,
  input  logic [bridge_pkg::NUM_SLAVES-1:0]      PSLVERR_i
);

  logic free;   // Response taken, decode may accept again

  apb_cmd_if  cmd_if ();
  apb_done_if done_if ();

  axi_req_decode u_decode (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .AWADDR_i  (AWADDR_i),
    .AWID_i    (AWID_i),
    .AWVALID_i (AWVALID_i),
    .AWREADY_o (AWREADY_o),
    .WDATA_i   (WDATA_i),
    .WVALID_i  (WVALID_i),
    .WREADY_o  (WREADY_o),
    .ARADDR_i  (ARADDR_i),
    .ARID_i    (ARID_i),
    .ARVALID_i (ARVALID_i),
    .ARREADY_o (ARREADY_o),
    .free_i    (free),
    .cmd       (cmd_if.decode)
  );

  apb_master_fsm u_apb (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .cmd       (cmd_if.execute),
    .done      (done_if.execute),
    .PSEL_o    (PSEL_o),
    .PENABLE_o (PENABLE_o),
    .PWRITE_o  (PWRITE_o),
    .PADDR_o   (PADDR_o),
    .PWDATA_o  (PWDATA_o),
    .PRDATA_i  (PRDATA_i),
    .PREADY_i  (PREADY_i),
    .PSLVERR_i (PSLVERR_i)
  );

  axi_resp_gen u_resp (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .done     (done_if.result),
    .BID_o    (BID_o),
    .BRESP_o  (BRESP_o),
    .BVALID_o (BVALID_o),
    .BREADY_i (BREADY_i),
    .RID_o    (RID_o),
    .RDATA_o  (RDATA_o),
    .RRESP_o  (RRESP_o),
    .RVALID_o (RVALID_o),
    .RREADY_i (RREADY_i),
    .free_o   (free)
  );

endmodule

//--- dv/apb_slave_model.sv
// Bank of eight APB slaves, 16 words each, word picked by PADDR bits 5:2
// Words reset to the slave index in the top byte plus the word index
// 0 to 3 wait states per transfer; slave 7 flags PSLVERR and ignores writes
`timescale 1ns/1ps

module apb_slave_model (
  input  logic                                              ACLK,
  input  logic                                              ARESETn,
  input  logic [bridge_pkg::NUM_SLAVES-1:0]                 psel_i,
  input  logic                                              penable_i,
  input  logic                                              pwrite_i,
  input  logic [bridge_pkg::APB_ADDR_W-1:0]                 paddr_i,
  input  logic [bridge_pkg::DATA_W-1:0]                     pwdata_i,
  output logic [bridge_pkg::NUM_SLAVES-1:0][bridge_pkg::DATA_W-1:0] prdata_o,
  output logic [bridge_pkg::NUM_SLAVES-1:0]                 pready_o,
  output logic [bridge_pkg::NUM_SLAVES-1:0]                 pslverr_o
);
  import bridge_pkg::*;

  localparam int          WORDS = 16;
  localparam logic [31:0] SEED  = 32'hf08c_1708;

  logic [DATA_W-1:0] mem [NUM_SLAVES][WORDS];
  logic [31:0]       rnd_q;
  logic [1:0]        wait_q;    // Wait states left in this access
  logic [SEL_W-1:0]  idx;
  logic [3:0]        word;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  assign word = paddr_i[5:2];

  always_comb
  begin
    idx = '0;
    for (int s = 0; s < NUM_SLAVES; s++)
    begin
      if (psel_i[s])
        idx = s[SEL_W-1:0];
      prdata_o[s]  = mem[s][word];
      pready_o[s]  = psel_i[s] & penable_i & (wait_q == 2'd0);
      pslverr_o[s] = psel_i[s] & penable_i & (s == NUM_SLAVES - 1);
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      rnd_q  <= SEED;
      wait_q <= 2'd0;
      for (int s = 0; s < NUM_SLAVES; s++)
        for (int w = 0; w < WORDS; w++)
          mem[s][w] <= {8'(s), 24'(w)};
    end
    else if (|psel_i)
    begin
      if (!penable_i)
      begin
        wait_q <= rnd_q[1:0];       // Drawn in the setup phase
        rnd_q  <= xorshift(rnd_q);
      end
      else if (wait_q != 2'd0)
        wait_q <= wait_q - 2'd1;
      else if (pwrite_i && idx != SEL_W'(NUM_SLAVES - 1))
        mem[idx][word] <= pwdata_i;
    end
  end

endmodule

//--- dv/tb_axi_apb_bridge.sv
// Testbench for the AXI4-to-APB bridge, run from the project root
// Requests and expected responses come from dv/bridge_stim.txt
// The next request is offered while the previous response is still pending
`timescale 1ns/1ps

module tb_axi_apb_bridge;
  import bridge_pkg::*;

  localparam int NUM_TESTS  = 14;
  localparam int COLS       = 7;    // op addr wdata rdata resp id flag
  localparam int MAX_CYCLES = (NUM_TESTS + 1) * 20;

  logic                              ACLK;
  logic                              ARESETn;
  logic [ADDR_W-1:0]                 aw_addr, ar_addr;
  logic [ID_W-1:0]                   aw_id, ar_id, b_id, r_id;
  logic                              aw_valid, aw_ready, w_valid, w_ready;
  logic                              ar_valid, ar_ready;
  logic [DATA_W-1:0]                 w_data, r_data;
  axi_resp_e                         b_resp, r_resp;
  logic                              b_valid, b_ready, r_valid, r_ready;
  logic [NUM_SLAVES-1:0]             psel, pready, pslverr;
  logic                              penable, pwrite;
  logic [APB_ADDR_W-1:0]             paddr;
  logic [DATA_W-1:0]                 pwdata;
  logic [NUM_SLAVES-1:0][DATA_W-1:0] prdata;

  logic [31:0] stim [0:NUM_TESTS*COLS-1];
  logic [31:0] rnd;
  int          resp_errs, data_errs, id_errs, other_errs;
  int          cycles = 0;

  axi_apb_bridge uut (
    .ACLK (ACLK), .ARESETn (ARESETn),
    .AWADDR_i (aw_addr), .AWID_i (aw_id), .AWVALID_i (aw_valid), .AWREADY_o (aw_ready),
    .WDATA_i (w_data), .WVALID_i (w_valid), .WREADY_o (w_ready),
    .BID_o (b_id), .BRESP_o (b_resp), .BVALID_o (b_valid), .BREADY_i (b_ready),
    .ARADDR_i (ar_addr), .ARID_i (ar_id), .ARVALID_i (ar_valid), .ARREADY_o (ar_ready),
    .RID_o (r_id), .RDATA_o (r_data), .RRESP_o (r_resp), .RVALID_o (r_valid),
    .RREADY_i (r_ready),
    .PSEL_o (psel), .PENABLE_o (penable), .PWRITE_o (pwrite), .PADDR_o (paddr),
    .PWDATA_o (pwdata), .PRDATA_i (prdata), .PREADY_i (pready), .PSLVERR_i (pslverr)
  );

  apb_slave_model u_slaves (
    .ACLK (ACLK), .ARESETn (ARESETn), .psel_i (psel), .penable_i (penable),
    .pwrite_i (pwrite), .paddr_i (paddr), .pwdata_i (pwdata),
    .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr)
  );

  initial
  begin
    ACLK = 1'b0;
    forever #20 ACLK = ~ACLK;
  end

  always @(posedge ACLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] stim_field(input int line, input int col);
    return stim[line*COLS + col];
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (act !== exp)
    begin
      resp_errs++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp)
    begin
      data_errs++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input logic [ID_W-1:0] exp,
                          input logic [ID_W-1:0] act);
    if (act !== exp)
    begin
      id_errs++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_fault(input string msg);
    other_errs++;
    $display("Fault: %s", msg);
  endtask

  // --------------------------------------------------------------------------
  // Request side
  // --------------------------------------------------------------------------
  task automatic offer_request(input int line);
    logic [31:0] op;
    op = stim_field(line, 0);
    if (op[0])
    begin
      aw_addr  <= stim_field(line, 1);
      aw_id    <= ID_W'(stim_field(line, 5));
      w_data   <= stim_field(line, 2);
      aw_valid <= 1'b1;
      w_valid  <= 1'b1;
    end
    else
    begin
      ar_addr  <= stim_field(line, 1);
      ar_id    <= ID_W'(stim_field(line, 5));
      ar_valid <= 1'b1;
    end
  endtask

  task automatic drive_requests();
    int i;
    i = 0;
    while (i < NUM_TESTS)
    begin
      offer_request(i);
      if (stim_field(i, 6) != 0)
      begin
        offer_request(i + 1);   // AR, AW and W in the same cycle
        i = i + 1;
      end
      @(posedge ACLK);
      while (ar_valid || aw_valid)
      begin
        if (aw_valid && (aw_ready !== w_ready))
          report_fault("AWREADY and WREADY differ");
        if (ar_valid && ar_ready)
          ar_valid <= 1'b0;
        if (aw_valid && aw_ready && w_ready)
        begin
          if (ar_valid)
            report_fault("write accepted ahead of a waiting read");
          aw_valid <= 1'b0;
          w_valid  <= 1'b0;
        end
        @(posedge ACLK);
      end
      i = i + 1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Response side, in stimulus order
  // --------------------------------------------------------------------------
  task automatic collect_responses();
    int                k;
    int                hold;
    logic [31:0]       op;
    logic [31:0]       exp_resp;
    logic              is_b;
    logic [ID_W-1:0]   id_seen;
    logic [DATA_W-1:0] data_seen;
    axi_resp_e         resp_seen;
    string             name;
    for (k = 0; k < NUM_TESTS; k++)
    begin
      op       = stim_field(k, 0);
      exp_resp = stim_field(k, 4);
      name     = $sformatf("line %0d", k + 1);
      @(posedge ACLK);
      while (!b_valid && !r_valid)
        @(posedge ACLK);
      is_b = b_valid;
      if (is_b !== op[0])
        report_fault($sformatf("%s: response came on the wrong channel", name));
      id_seen   = is_b ? b_id : r_id;
      resp_seen = is_b ? b_resp : r_resp;
      data_seen = r_data;
      rnd  = xorshift(rnd);
      hold = int'(rnd[1:0]);    // Back-pressure cycles
      repeat (hold)
      begin
        @(posedge ACLK);
        if (is_b ? (!b_valid || b_id !== id_seen || b_resp !== resp_seen)
                 : (!r_valid || r_id !== id_seen || r_resp !== resp_seen ||
                    r_data !== data_seen))
          report_fault($sformatf("%s: response changed under back-pressure", name));
        if (ar_ready || aw_ready || w_ready)
          report_fault($sformatf("%s: request accepted during back-pressure", name));
      end
      if (is_b)
        b_ready <= 1'b1;
      else
        r_ready <= 1'b1;
      @(posedge ACLK);          // Handshake edge
      b_ready <= 1'b0;
      r_ready <= 1'b0;
      check_resp({name, " resp"}, axi_resp_e'(exp_resp[1:0]), resp_seen);
      check_id({name, " id"}, ID_W'(stim_field(k, 5)), id_seen);
      if (!op[0])
        check_data({name, " rdata"}, stim_field(k, 3), data_seen);
    end
  endtask

  initial
  begin
    ARESETn    = 1'b0;
    aw_addr    = '0;
    aw_id      = '0;
    aw_valid   = 1'b0;
    w_data     = '0;
    w_valid    = 1'b0;
    ar_addr    = '0;
    ar_id      = '0;
    ar_valid   = 1'b0;
    b_ready    = 1'b0;
    r_ready    = 1'b0;
    rnd        = 32'hf08c_1708;
    resp_errs  = 0;
    data_errs  = 0;
    id_errs    = 0;
    other_errs = 0;
    $readmemh("dv/bridge_stim.txt", stim);

    repeat (3) @(posedge ACLK);
    if (aw_ready || w_ready || ar_ready || b_valid || r_valid || (|psel) || penable)
      report_fault("handshake or APB outputs not low in reset");
    ARESETn <= 1'b1;

    fork
      drive_requests();
      collect_responses();
    join

    $display("Errors: resp %0d, data %0d, id %0d, other %0d",
             resp_errs, data_errs, id_errs, other_errs);
    if (resp_errs + data_errs + id_errs + other_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- list.f
verilog/bridge_pkg.sv
verilog/apb_cmd_if.sv
verilog/apb_done_if.sv
verilog/axi_req_decode.sv
verilog/apb_master_fsm.sv
verilog/axi_resp_gen.sv
verilog/axi_apb_bridge.sv
dv/apb_slave_model.sv
dv/tb_axi_apb_bridge.sv

//--- dv/bridge_stim.txt
// op addr wdata exp_rdata exp_resp id flag  (all hex, one transaction per line)
// op 1 = write, resp 0 = OKAY 2 = SLVERR, flag 1 = offered together with the next line
0 00000008 00000000 00000002 0 11 0
0 00003010 00000000 03000004 0 12 0
1 00001004 A5A50001 00000000 0 21 0
1 00002004 5A5A0002 00000000 0 22 0
0 00001004 00000000 A5A50001 0 23 0
0 00002004 00000000 5A5A0002 0 24 0
1 0000703C DEADBEEF 00000000 2 71 0
0 0000703C 00000000 0700000F 2 72 0
0 00004020 00000000 04000008 0 41 1
1 00004020 12345678 00000000 0 42 0
0 00004020 00000000 12345678 0 43 0
0 8000600C 00000000 06000003 0 61 0
1 00000030 0BADC0DE 00000000 0 01 0
0 00000030 00000000 0BADC0DE 0 02 0
